// File: common/game_pkg.sv
// Game collision definitions
`default_nettype none

package game_pkg;

	// ------------------------------------------------------------
	// widths and vector types
	// ------------------------------------------------------------
	typedef logic [9:0] coord_t;                       // one pixel column or row
	typedef logic [9:0] hit_request_t;                 // one draw request per drawable item
	typedef logic [8:0] collision_t;                   // one bit per collision type
	typedef logic [7:0] hit_count_t;                   // pulse count of one collision type

	// draw request bit positions
	localparam int REQ_EDGE_BOUNDARY   = 0;
	localparam int REQ_MIDDLE_BOUNDARY = 1;
	localparam int REQ_PLAYER          = 2;            // first movable object
	localparam int REQ_PLAYER_MISSILE  = 3;
	localparam int REQ_MONSTER         = 4;
	localparam int REQ_ENEMY_MISSILE_A = 5;
	localparam int REQ_ASTEROID        = 6;
	localparam int REQ_BOSS            = 7;
	localparam int REQ_ENEMY_MISSILE_B = 8;
	localparam int REQ_GIFT            = 9;

	localparam int NUM_OBJECTS = 8;                    // object i drives request bit i+2

	// collision bit positions
	localparam int COLLISION_ENEMY_MISSILE         = 0;
	localparam int COLLISION_ENEMY_ANY_BOUNDARY    = 1;
	localparam int COLLISION_MISSILE_FAR_BOUNDARY  = 2;
	localparam int COLLISION_PLAYER_ANY_BOUNDARY   = 3;
	localparam int COLLISION_PLAYER_MISSILE        = 4;
	localparam int COLLISION_ENEMY_FAR_BOUNDARY    = 5;
	localparam int COLLISION_PLAYER_ENEMY          = 6;
	localparam int COLLISION_PLAYER_GIFT           = 7;
	localparam int COLLISION_GIFT_BOUNDARY         = 8;

	localparam int NUM_COLLISIONS = 9;

	// ------------------------------------------------------------
	// object box sizes in pixels, indexed by object number
	// ------------------------------------------------------------
	// order is player, player missile, monster, missile a, asteroid, boss, missile b, gift
	localparam coord_t OBJ_WIDTH  [NUM_OBJECTS] = '{10'd4, 10'd1, 10'd4, 10'd1,
		10'd3, 10'd6, 10'd1, 10'd2};
	localparam coord_t OBJ_HEIGHT [NUM_OBJECTS] = '{10'd3, 10'd2, 10'd3, 10'd2,
		10'd3, 10'd4, 10'd2, 10'd2};

endpackage

`default_nettype wire

// File: common/scan_if.sv
// Raster scan position bus
`timescale 1ns/1ps
`default_nettype none

interface scan_if;

	game_pkg::coord_t pixel_x;                         // current column of the scan
	game_pkg::coord_t pixel_y;                         // current row of the scan
	logic start_of_frame;                              // one cycle high while the scan sits on 0,0
	logic scan_active;                                 // high once the scanner has started

	// the scanner owns every signal of the bus
	modport source (
		output pixel_x,
		output pixel_y,
		output start_of_frame,
		output scan_active
	);

	// object and boundary decoders only look at the position
	modport sink (
		input pixel_x,
		input pixel_y,
		input start_of_frame,
		input scan_active
	);

endinterface

`default_nettype wire

// File: src/frame_scanner.sv
// Frame position scanner
`timescale 1ns/1ps
`default_nettype none

module frame_scanner #(
	parameter int FRAME_WIDTH  = 32,
	parameter int FRAME_HEIGHT = 24
) (
	input  logic   clk,
	input  logic   resetN,
	scan_if.source scan
);

	localparam game_pkg::coord_t LAST_COL = game_pkg::coord_t'(FRAME_WIDTH - 1);  // wrap column
	localparam game_pkg::coord_t LAST_ROW = game_pkg::coord_t'(FRAME_HEIGHT - 1); // wrap row

	game_pkg::coord_t col_cnt;                         // running column counter
	game_pkg::coord_t row_cnt;                         // running row counter
	logic             sof_reg;                         // start of frame, aligned with the counters
	logic             running;                         // set on the first edge after reset

	// ------------------------------------------------------------
	// column and row counters
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			col_cnt <= '0;
			row_cnt <= '0;
			sof_reg <= 1'b0;
			running <= 1'b0;
		end else if (!running) begin
			running <= 1'b1;                           // hold 0,0 for one more cycle and mark it
			sof_reg <= 1'b1;
		end else begin
			sof_reg <= (col_cnt == LAST_COL) && (row_cnt == LAST_ROW); // next cycle is 0,0
			if (col_cnt == LAST_COL) begin
				col_cnt <= '0;                         // end of line
				row_cnt <= (row_cnt == LAST_ROW) ? '0 : row_cnt + 1'b1;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	assign scan.pixel_x        = col_cnt;
	assign scan.pixel_y        = row_cnt;
	assign scan.start_of_frame = sof_reg;
	assign scan.scan_active    = running;

	// position never leaves the frame, also across the idle cycle after reset
	a_position_in_frame: assert property (@(posedge clk) disable iff (!resetN)
		(col_cnt < LAST_COL + 1'b1) && (row_cnt < LAST_ROW + 1'b1));

endmodule

`default_nettype wire

// File: src/object_box.sv
// Object rectangle decoder
`timescale 1ns/1ps
`default_nettype none

module object_box #(
	parameter int OBJ_INDEX = 0                        // selects the box size from the tables
) (
	scan_if.sink             scan,
	input  game_pkg::coord_t obj_x,                    // left column of the box
	input  game_pkg::coord_t obj_y,                    // top row of the box
	input  logic             obj_active,
	output logic             draw_request
);

	localparam game_pkg::coord_t BOX_W = game_pkg::OBJ_WIDTH[OBJ_INDEX];
	localparam game_pkg::coord_t BOX_H = game_pkg::OBJ_HEIGHT[OBJ_INDEX];

	logic [10:0] x_end;                                // one past the right column, no wrap
	logic [10:0] y_end;                                // one past the bottom row, no wrap
	logic        inside_x;
	logic        inside_y;

	assign x_end = {1'b0, obj_x} + {1'b0, BOX_W};
	assign y_end = {1'b0, obj_y} + {1'b0, BOX_H};

	// the box covers obj_x up to obj_x plus width minus one
	assign inside_x = (scan.pixel_x >= obj_x) && ({1'b0, scan.pixel_x} < x_end);
	assign inside_y = (scan.pixel_y >= obj_y) && ({1'b0, scan.pixel_y} < y_end);

	// nothing is drawn before the scanner has started
	assign draw_request = obj_active && inside_x && inside_y && scan.scan_active;

endmodule

`default_nettype wire

// File: src/boundary_map.sv
// Playfield boundary decoder
`timescale 1ns/1ps
`default_nettype none

module boundary_map #(
	parameter int FRAME_WIDTH  = 32,
	parameter int FRAME_HEIGHT = 24
) (
	scan_if.sink scan,
	output logic edge_request,                         // outer frame ring
	output logic middle_request                        // horizontal line across the middle
);

	localparam game_pkg::coord_t LAST_COL = game_pkg::coord_t'(FRAME_WIDTH - 1);
	localparam game_pkg::coord_t LAST_ROW = game_pkg::coord_t'(FRAME_HEIGHT - 1);
	localparam game_pkg::coord_t MID_ROW  = game_pkg::coord_t'(FRAME_HEIGHT / 2);

	logic on_edge;

	// first and last column or row
	assign on_edge = (scan.pixel_x == '0) || (scan.pixel_x == LAST_COL) ||
		(scan.pixel_y == '0) || (scan.pixel_y == LAST_ROW);

	assign edge_request   = on_edge && scan.scan_active;
	assign middle_request = (scan.pixel_y == MID_ROW) && scan.scan_active;

endmodule

`default_nettype wire

// File: hit_detection/hit_detection.sv
// Collision detector
`timescale 1ns/1ps
`default_nettype none

module hit_detection (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   start_of_frame,     // one cycle pulse at 0,0
	input  game_pkg::hit_request_t hit_request,
	output game_pkg::collision_t   collision,          // level, same cycle as the requests
	output game_pkg::collision_t   hit_pulse           // at most once per type per frame
);

	logic edge_boundary;
	logic all_boundaries;
	logic player;
	logic player_missile;
	logic enemy_missile;
	logic any_missile;
	logic constrained_enemies;
	logic unconstrained_enemy;
	logic any_enemy;
	logic gift;

	game_pkg::collision_t flags;                       // set once a type has pulsed this frame
	game_pkg::collision_t armed_flags;                 // flags as seen by the current cycle

	// ------------------------------------------------------------
	// request groups
	// ------------------------------------------------------------
	assign edge_boundary  = hit_request[game_pkg::REQ_EDGE_BOUNDARY];
	assign all_boundaries = edge_boundary | hit_request[game_pkg::REQ_MIDDLE_BOUNDARY];
	assign player         = hit_request[game_pkg::REQ_PLAYER];
	assign player_missile = hit_request[game_pkg::REQ_PLAYER_MISSILE];
	assign enemy_missile  = hit_request[game_pkg::REQ_ENEMY_MISSILE_A] |
		hit_request[game_pkg::REQ_ENEMY_MISSILE_B];
	assign any_missile    = enemy_missile | player_missile;
	assign constrained_enemies = hit_request[game_pkg::REQ_BOSS] |
		hit_request[game_pkg::REQ_MONSTER];
	assign unconstrained_enemy = hit_request[game_pkg::REQ_ASTEROID];
	assign any_enemy      = constrained_enemies | unconstrained_enemy;
	assign gift           = hit_request[game_pkg::REQ_GIFT];

	// ------------------------------------------------------------
	// collision levels
	// ------------------------------------------------------------
	assign collision[game_pkg::COLLISION_ENEMY_MISSILE] = any_enemy & player_missile;
	assign collision[game_pkg::COLLISION_ENEMY_ANY_BOUNDARY] = constrained_enemies & all_boundaries;
	assign collision[game_pkg::COLLISION_MISSILE_FAR_BOUNDARY] = any_missile & edge_boundary;
	assign collision[game_pkg::COLLISION_PLAYER_ANY_BOUNDARY] = player & all_boundaries;
	assign collision[game_pkg::COLLISION_PLAYER_MISSILE] = player & enemy_missile;
	assign collision[game_pkg::COLLISION_ENEMY_FAR_BOUNDARY] = unconstrained_enemy & edge_boundary;
	assign collision[game_pkg::COLLISION_PLAYER_ENEMY] = player & any_enemy;
	assign collision[game_pkg::COLLISION_PLAYER_GIFT] = player & gift;
	assign collision[game_pkg::COLLISION_GIFT_BOUNDARY] = gift & edge_boundary;

	// a start of frame cycle already belongs to the new frame, so old flags are ignored there
	assign armed_flags = start_of_frame ? '0 : flags;

	// ------------------------------------------------------------
	// once per frame pulses
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			flags     <= '0;
			hit_pulse <= '0;
		end else begin
			for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++) begin
				hit_pulse[k] <= collision[k] & ~armed_flags[k];  // first hit of the frame only
				flags[k]     <= armed_flags[k] | collision[k];   // stays set until next frame
			end
		end
	end

	// a type that has already pulsed in this frame stays quiet until start_of_frame
	for (genvar k = 0; k < game_pkg::NUM_COLLISIONS; k++) begin : g_pulse_check
		a_single_pulse: assert property (@(posedge clk) disable iff (!resetN)
			flags[k] && !start_of_frame |=> !hit_pulse[k]);
	end

endmodule

`default_nettype wire

// File: hit_detection/hit_event_counter.sv
// Collision event counters
`timescale 1ns/1ps
`default_nettype none

module hit_event_counter (
	input  logic                 clk,
	input  logic                 resetN,
	input  game_pkg::collision_t hit_pulse,            // one cycle per counted event
	input  logic                 clear_counts,         // zeroes every counter on the next edge
	output game_pkg::hit_count_t hit_count [game_pkg::NUM_COLLISIONS]
);

	localparam game_pkg::hit_count_t COUNT_MAX = '1;   // counters stick here

	// ------------------------------------------------------------
	// one saturating counter per collision type
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++) begin
				hit_count[k] <= '0;
			end
		end else begin
			for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++) begin
				if (clear_counts) begin
					hit_count[k] <= '0;                // clear wins over a pulse in the same cycle
				end else if (hit_pulse[k] && (hit_count[k] != COUNT_MAX)) begin
					hit_count[k] <= hit_count[k] + 1'b1;
				end
			end
		end
	end

	// a full counter only leaves its maximum through clear_counts
	for (genvar k = 0; k < game_pkg::NUM_COLLISIONS; k++) begin : g_sat_check
		a_no_wrap: assert property (@(posedge clk) disable iff (!resetN)
			(hit_count[k] == COUNT_MAX) && !clear_counts |=> hit_count[k] == COUNT_MAX);
	end

endmodule

`default_nettype wire

// File: src/game_hit_top.sv
// Game collision top level
`timescale 1ns/1ps
`default_nettype none

module game_hit_top #(
	parameter int FRAME_WIDTH  = 32,
	parameter int FRAME_HEIGHT = 24
) (
	input  logic                                clk,
	input  logic                                resetN,
	input  game_pkg::coord_t                    obj_x [game_pkg::NUM_OBJECTS], // left columns
	input  game_pkg::coord_t                    obj_y [game_pkg::NUM_OBJECTS], // top rows
	input  logic [game_pkg::NUM_OBJECTS-1:0]    obj_active,
	input  logic                                clear_counts,
	output game_pkg::coord_t                    pixel_x,
	output game_pkg::coord_t                    pixel_y,
	output logic                                start_of_frame,
	output game_pkg::collision_t                collision,
	output game_pkg::collision_t                hit_pulse,
	output game_pkg::hit_count_t                hit_count [game_pkg::NUM_COLLISIONS]
);

	scan_if scan ();                                   // position bus from the scanner

	wire game_pkg::hit_request_t hit_request;          // each bit has its own decoder

	// ------------------------------------------------------------
	// scan position
	// ------------------------------------------------------------
	frame_scanner #(
		.FRAME_WIDTH  (FRAME_WIDTH),
		.FRAME_HEIGHT (FRAME_HEIGHT)
	) u_frame_scanner (
		.clk    (clk),
		.resetN (resetN),
		.scan   (scan.source)
	);

	// ------------------------------------------------------------
	// draw requests
	// ------------------------------------------------------------
	for (genvar i = 0; i < game_pkg::NUM_OBJECTS; i++) begin : g_object
		object_box #(
			.OBJ_INDEX (i)
		) u_object_box (
			.scan         (scan.sink),
			.obj_x        (obj_x[i]),
			.obj_y        (obj_y[i]),
			.obj_active   (obj_active[i]),
			.draw_request (hit_request[game_pkg::REQ_PLAYER + i])  // objects start at bit 2
		);
	end

	boundary_map #(
		.FRAME_WIDTH  (FRAME_WIDTH),
		.FRAME_HEIGHT (FRAME_HEIGHT)
	) u_boundary_map (
		.scan           (scan.sink),
		.edge_request   (hit_request[game_pkg::REQ_EDGE_BOUNDARY]),
		.middle_request (hit_request[game_pkg::REQ_MIDDLE_BOUNDARY])
	);

	// ------------------------------------------------------------
	// collisions and counting
	// ------------------------------------------------------------
	hit_detection u_hit_detection (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (scan.start_of_frame),
		.hit_request    (hit_request),
		.collision      (collision),
		.hit_pulse      (hit_pulse)
	);

	hit_event_counter u_hit_event_counter (
		.clk          (clk),
		.resetN       (resetN),
		.hit_pulse    (hit_pulse),
		.clear_counts (clear_counts),
		.hit_count    (hit_count)
	);

	// scan position is also visible outside for checking
	assign pixel_x        = scan.pixel_x;
	assign pixel_y        = scan.pixel_y;
	assign start_of_frame = scan.start_of_frame;

endmodule

`default_nettype wire

// File: sim/tb_game_hit_top.sv
// Collision detector testbench
`timescale 1ns/1ps
`default_nettype none

module tb_game_hit_top;

	localparam int FRAME_WIDTH  = 32;
	localparam int FRAME_HEIGHT = 24;
	localparam int FRAME_CYCLES = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int RANDOM_FRAMES = 20;                 // frames with LCG object placement
	localparam int SAT_FRAMES    = 262;                // enough pulses to pass 255
	localparam int TEST_FRAMES   = RANDOM_FRAMES + SAT_FRAMES + 8;
	localparam int WATCHDOG_NS   = (TEST_FRAMES * FRAME_CYCLES + 1000) * 10;

	logic                         clk = 1'b0;
	logic                         resetN;
	game_pkg::coord_t             obj_x [game_pkg::NUM_OBJECTS];
	game_pkg::coord_t             obj_y [game_pkg::NUM_OBJECTS];
	logic [game_pkg::NUM_OBJECTS-1:0] obj_active;
	logic                         clear_counts;
	game_pkg::coord_t             pixel_x;
	game_pkg::coord_t             pixel_y;
	logic                         start_of_frame;
	game_pkg::collision_t         collision;
	game_pkg::collision_t         hit_pulse;
	game_pkg::hit_count_t         hit_count [game_pkg::NUM_COLLISIONS];

	int unsigned                  rng_state;           // LCG state
	logic                         started;             // first start_of_frame seen since reset
	int                           wait_cycles;         // cycles since reset release without a frame
	game_pkg::coord_t             exp_x;
	game_pkg::coord_t             exp_y;
	game_pkg::collision_t         exp_col;
	game_pkg::collision_t         exp_flags;           // types already pulsed in this frame
	game_pkg::collision_t         exp_pulse;           // pulse expected in the current cycle
	game_pkg::collision_t         armed;
	game_pkg::collision_t         pulsed_types;        // every type that pulsed during the run
	game_pkg::hit_count_t         exp_count [game_pkg::NUM_COLLISIONS];

	game_hit_top #(
		.FRAME_WIDTH  (FRAME_WIDTH),
		.FRAME_HEIGHT (FRAME_HEIGHT)
	) u_dut (
		.clk            (clk),
		.resetN         (resetN),
		.obj_x          (obj_x),
		.obj_y          (obj_y),
		.obj_active     (obj_active),
		.clear_counts   (clear_counts),
		.pixel_x        (pixel_x),
		.pixel_y        (pixel_y),
		.start_of_frame (start_of_frame),
		.collision      (collision),
		.hit_pulse      (hit_pulse),
		.hit_count      (hit_count)
	);

	always #5 clk = ~clk;                              // 10 ns period

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic int unsigned next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state >> 8;                         // low bits of an LCG are weak
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_collision(input string name, input game_pkg::collision_t got,
		input game_pkg::collision_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] time=%0t %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_count(input string name, input game_pkg::hit_count_t got,
		input game_pkg::hit_count_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] time=%0t %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_coord(input string name, input game_pkg::coord_t got,
		input game_pkg::coord_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] time=%0t %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] time=%0t %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// collision set for one pixel under the current object settings
	function automatic game_pkg::collision_t ref_collision(input game_pkg::coord_t px,
		input game_pkg::coord_t py);
		game_pkg::hit_request_t req;
		game_pkg::collision_t   col;
		logic edge_b;
		logic all_b;
		logic enemy_m;
		logic con_e;
		logic any_e;
		req = '0;
		for (int i = 0; i < game_pkg::NUM_OBJECTS; i++) begin
			if (obj_active[i] && (int'(px) >= int'(obj_x[i])) &&
				(int'(px) < int'(obj_x[i]) + int'(game_pkg::OBJ_WIDTH[i])) &&
				(int'(py) >= int'(obj_y[i])) &&
				(int'(py) < int'(obj_y[i]) + int'(game_pkg::OBJ_HEIGHT[i])))
				req[game_pkg::REQ_PLAYER + i] = 1'b1;  // object i is bit i+2
		end
		req[game_pkg::REQ_EDGE_BOUNDARY] = (px == 0) || (px == FRAME_WIDTH - 1) ||
			(py == 0) || (py == FRAME_HEIGHT - 1);
		req[game_pkg::REQ_MIDDLE_BOUNDARY] = (py == FRAME_HEIGHT / 2);
		edge_b  = req[game_pkg::REQ_EDGE_BOUNDARY];
		all_b   = edge_b | req[game_pkg::REQ_MIDDLE_BOUNDARY];
		enemy_m = req[game_pkg::REQ_ENEMY_MISSILE_A] | req[game_pkg::REQ_ENEMY_MISSILE_B];
		con_e   = req[game_pkg::REQ_BOSS] | req[game_pkg::REQ_MONSTER];
		any_e   = con_e | req[game_pkg::REQ_ASTEROID];
		col[game_pkg::COLLISION_ENEMY_MISSILE] = any_e & req[game_pkg::REQ_PLAYER_MISSILE];
		col[game_pkg::COLLISION_ENEMY_ANY_BOUNDARY] = con_e & all_b;
		col[game_pkg::COLLISION_MISSILE_FAR_BOUNDARY] =
			(enemy_m | req[game_pkg::REQ_PLAYER_MISSILE]) & edge_b;
		col[game_pkg::COLLISION_PLAYER_ANY_BOUNDARY] = req[game_pkg::REQ_PLAYER] & all_b;
		col[game_pkg::COLLISION_PLAYER_MISSILE] = req[game_pkg::REQ_PLAYER] & enemy_m;
		col[game_pkg::COLLISION_ENEMY_FAR_BOUNDARY] = req[game_pkg::REQ_ASTEROID] & edge_b;
		col[game_pkg::COLLISION_PLAYER_ENEMY] = req[game_pkg::REQ_PLAYER] & any_e;
		col[game_pkg::COLLISION_PLAYER_GIFT] = req[game_pkg::REQ_PLAYER] & req[game_pkg::REQ_GIFT];
		col[game_pkg::COLLISION_GIFT_BOUNDARY] = req[game_pkg::REQ_GIFT] & edge_b;
		return col;
	endfunction

	// ------------------------------------------------------------
	// compare process, samples mid cycle
	// ------------------------------------------------------------
	always @(negedge clk) begin
		if (!resetN) begin
			check_collision("hit_pulse in reset", hit_pulse, '0);
			for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++)
				check_count($sformatf("hit_count[%0d] in reset", k), hit_count[k], '0);
			check_flag("start_of_frame in reset", start_of_frame, 1'b0);
			started     = 1'b0;
			wait_cycles = 0;
			exp_flags   = '0;
			exp_pulse   = '0;
			for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++)
				exp_count[k] = '0;
		end else begin
			if (!started && start_of_frame === 1'b1) begin
				started = 1'b1;                        // scan restarts at 0,0
				exp_x   = '0;
				exp_y   = '0;
			end else if (!started) begin
				check_coord("pixel_x before first frame", pixel_x, '0);
				check_coord("pixel_y before first frame", pixel_y, '0);
				wait_cycles++;
				if (wait_cycles > 2)
					report_failure("start_of_frame did not follow the reset release");
			end
			if (started) begin
				check_coord("pixel_x", pixel_x, exp_x);
				check_coord("pixel_y", pixel_y, exp_y);
				check_flag("start_of_frame", start_of_frame, (exp_x == 0) && (exp_y == 0));
			end
			exp_col = started ? ref_collision(pixel_x, pixel_y) : '0;
			check_collision("collision", collision, exp_col);
			check_collision("hit_pulse", hit_pulse, exp_pulse);
			for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++)
				check_count($sformatf("hit_count[%0d]", k), hit_count[k], exp_count[k]);
			pulsed_types |= hit_pulse;
			// counters take this cycle's pulse on the next edge, clear wins
			for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++) begin
				if (clear_counts)
					exp_count[k] = '0;
				else if (exp_pulse[k] && exp_count[k] != 8'd255)
					exp_count[k] = exp_count[k] + 1'b1;
			end
			// the 0,0 cycle belongs to the new frame
			armed     = (started && exp_x == 0 && exp_y == 0) ? '0 : exp_flags;
			exp_pulse = exp_col & ~armed;
			exp_flags = armed | exp_col;
			if (started) begin
				if (exp_x == FRAME_WIDTH - 1) begin
					exp_x = '0;
					exp_y = (exp_y == FRAME_HEIGHT - 1) ? '0 : exp_y + 1'b1;
				end else begin
					exp_x = exp_x + 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic apply_reset();
		resetN = 1'b0;
		repeat (4) @(posedge clk);
		#1 resetN = 1'b1;
	endtask

	// returns 1 ns into the cycle after a start_of_frame
	task automatic wait_frame_start();
		do @(negedge clk); while (start_of_frame !== 1'b1);
		@(posedge clk);
		#1;
	endtask

	task automatic place_random_objects();
		for (int i = 0; i < game_pkg::NUM_OBJECTS; i++) begin
			obj_x[i] = game_pkg::coord_t'(next_rand() % 16);  // crowded left half
			obj_y[i] = game_pkg::coord_t'(next_rand() % 14);  // reaches the middle row
		end
		obj_active = 8'(next_rand() | next_rand());           // about three in four active
	endtask

	// overlaps built to hit all nine collision types in one frame
	task automatic place_hand_objects();
		obj_x = '{10'd0, 10'd5, 10'd2, 10'd1, 10'd10, 10'd20, 10'd31, 10'd0};
		obj_y = '{10'd11, 10'd14, 10'd12, 10'd13, 10'd0, 10'd20, 10'd5, 10'd10};
		obj_active = '1;
	endtask

	game_pkg::collision_t idle_seen;

	initial begin
		resetN       = 1'b0;
		clear_counts = 1'b0;
		obj_active   = '0;
		pulsed_types = '0;
		rng_state    = 32'd64156;
		for (int i = 0; i < game_pkg::NUM_OBJECTS; i++) begin
			obj_x[i] = '0;
			obj_y[i] = '0;
		end
		apply_reset();
		repeat (RANDOM_FRAMES) begin
			wait_frame_start();
			place_random_objects();
		end
		wait_frame_start();
		place_hand_objects();
		wait_frame_start();
		obj_active = '0;                               // everything gone for a whole frame
		idle_seen  = '0;
		do begin
			@(negedge clk);
			idle_seen |= collision;
		end while (start_of_frame !== 1'b1);
		check_collision("collisions in idle frame", idle_seen, '0);
		@(posedge clk);
		#1;
		obj_x[0]   = '0;                               // player parked in the corner
		obj_y[0]   = '0;
		obj_active = 8'h01;
		repeat (SAT_FRAMES) wait_frame_start();
		check_count("saturated hit_count", hit_count[game_pkg::COLLISION_PLAYER_ANY_BOUNDARY],
			8'd255);
		clear_counts = 1'b1;                           // lands on the corner pulse
		@(negedge clk);
		check_flag("hit_pulse during clear",
			hit_pulse[game_pkg::COLLISION_PLAYER_ANY_BOUNDARY], 1'b1);
		@(posedge clk);
		#1 clear_counts = 1'b0;
		@(negedge clk);
		for (int k = 0; k < game_pkg::NUM_COLLISIONS; k++)
			check_count($sformatf("hit_count[%0d] after clear", k), hit_count[k], '0);
		repeat (40) @(posedge clk);
		#1;
		apply_reset();                                 // restart in the middle of a frame
		wait_frame_start();
		place_random_objects();
		wait_frame_start();
		check_collision("types that pulsed", pulsed_types, '1);
		$display("Result: PASSED");
		$finish;
	end

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog timeout, the test did not finish in time");
	end

endmodule

`default_nettype wire

// File: build.f
common/game_pkg.sv
common/scan_if.sv
src/frame_scanner.sv
src/object_box.sv
src/boundary_map.sv
hit_detection/hit_detection.sv
hit_detection/hit_event_counter.sv
src/game_hit_top.sv
sim/tb_game_hit_top.sv
